/* src/acc_disp_pkg.sv */
// Widths, vector types, FSM-free enums and queue depth for the accelerator dispatcher
package acc_disp_pkg;

  // Datapath widths
  localparam int XLEN = 64;
  localparam int INSN_W = 32;

  // Scoreboard size, one bitmap bit per entry
  localparam int NR_SB_ENTRIES = 8;
  localparam int TRANS_ID_W = $clog2(NR_SB_ENTRIES);

  // Instruction queue in front of the request register
  localparam int INSN_QUEUE_DEPTH = 3;
  localparam int QUEUE_CNT_W = $clog2(INSN_QUEUE_DEPTH + 1);

  // Outstanding accelerator loads or stores per counter
  localparam int LS_CNT_W = 3;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [INSN_W-1:0] insn_t;
  typedef logic [TRANS_ID_W-1:0] trans_id_t;
  typedef logic [QUEUE_CNT_W-1:0] queue_cnt_t;
  typedef logic [LS_CNT_W-1:0] ls_cnt_t;

  // Functional unit of the instruction at issue
  typedef enum logic [1:0] {
    FU_NONE,
    FU_LOAD,
    FU_STORE,
    FU_ACCEL
  } fu_e;

  // Memory class of an accelerator instruction
  typedef enum logic [1:0] {
    ACC_OP_OTHER,
    ACC_OP_LOAD,
    ACC_OP_STORE
  } acc_op_e;

endpackage

/* src/acc_req_if.sv */
// Dispatch handshake interface between instruction queue, request stage and trackers
`timescale 1ns/100ps

interface acc_req_if;

  // Handshake, a dispatch is valid and ready on the same edge
  logic valid;
  logic ready;

  // Request payload, stable while valid waits for ready
  acc_disp_pkg::insn_t insn;
  acc_disp_pkg::xlen_t rs1;
  acc_disp_pkg::xlen_t rs2;
  acc_disp_pkg::trans_id_t trans_id;
  acc_disp_pkg::acc_op_e op;

  // Queue side, offers the non-speculative head
  modport source (
    output valid,
    output insn,
    output rs1,
    output rs2,
    output trans_id,
    output op,
    input  ready
  );

  // Request register side
  modport sink (
    input  valid,
    input  insn,
    input  rs1,
    input  rs2,
    input  trans_id,
    input  op,
    output ready
  );

  // Trackers watch dispatches only
  modport monitor (
    input valid,
    input ready,
    input insn,
    input rs1,
    input rs2,
    input trans_id,
    input op
  );

endinterface

/* src/acc_insn_queue.sv */
// Fall-through accelerator instruction queue with head gated on non-speculation
`timescale 1ns/100ps

module acc_insn_queue (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    push_i,
  input  logic                    flush_i,
  input  acc_disp_pkg::insn_t     insn_i,
  input  acc_disp_pkg::xlen_t     rs1_i,
  input  acc_disp_pkg::xlen_t     rs2_i,
  input  acc_disp_pkg::trans_id_t trans_id_i,
  input  acc_disp_pkg::acc_op_e   op_i,
  input  logic                    head_nonspec_i,
  output logic                    head_valid_o,
  output acc_disp_pkg::trans_id_t head_trans_id_o,
  output logic                    queue_full_o,
  acc_req_if.source               req
);

  // Storage, one slot per queue entry
  acc_disp_pkg::insn_t     insn_mem     [acc_disp_pkg::INSN_QUEUE_DEPTH];
  acc_disp_pkg::xlen_t     rs1_mem      [acc_disp_pkg::INSN_QUEUE_DEPTH];
  acc_disp_pkg::xlen_t     rs2_mem      [acc_disp_pkg::INSN_QUEUE_DEPTH];
  acc_disp_pkg::trans_id_t trans_id_mem [acc_disp_pkg::INSN_QUEUE_DEPTH];
  acc_disp_pkg::acc_op_e   op_mem       [acc_disp_pkg::INSN_QUEUE_DEPTH];

  acc_disp_pkg::queue_cnt_t rd_ptr_q;
  acc_disp_pkg::queue_cnt_t wr_ptr_q;
  acc_disp_pkg::queue_cnt_t count_q;

  logic push;
  logic pop;

  // Circular pointer advance, wraps at the last slot
  function automatic acc_disp_pkg::queue_cnt_t next_ptr(input acc_disp_pkg::queue_cnt_t ptr);
    if (ptr == acc_disp_pkg::queue_cnt_t'(acc_disp_pkg::INSN_QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign queue_full_o = (count_q == acc_disp_pkg::queue_cnt_t'(acc_disp_pkg::INSN_QUEUE_DEPTH));
  assign head_valid_o = (count_q != '0);
  assign head_trans_id_o = trans_id_mem[rd_ptr_q];

  // Head leaves only once it reached the scoreboard head
  assign req.valid = head_valid_o && head_nonspec_i;
  assign req.insn = insn_mem[rd_ptr_q];
  assign req.rs1 = rs1_mem[rd_ptr_q];
  assign req.rs2 = rs2_mem[rd_ptr_q];
  assign req.trans_id = trans_id_mem[rd_ptr_q];
  assign req.op = op_mem[rd_ptr_q];

  assign pop = req.valid && req.ready;
  // A push into a full queue is only taken when a slot frees on the same edge
  assign push = push_i && (!queue_full_o || pop);

  // Pointers and occupancy, flush empties the queue
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push, pop})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Payload write, no reset on the storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      insn_mem[wr_ptr_q] <= insn_i;
      rs1_mem[wr_ptr_q] <= rs1_i;
      rs2_mem[wr_ptr_q] <= rs2_i;
      trans_id_mem[wr_ptr_q] <= trans_id_i;
      op_mem[wr_ptr_q] <= op_i;
    end
  end

endmodule

/* src/acc_spec_tracker.sv */
// Pending and ready bitmaps per transaction ID, deciding when the queue head is non-speculative
`timescale 1ns/100ps

module acc_spec_tracker (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    flush_i,
  input  logic                    push_i,
  input  acc_disp_pkg::trans_id_t push_trans_id_i,
  input  logic                    commit_valid_i,
  input  acc_disp_pkg::trans_id_t commit_trans_id_i,
  input  logic                    head_valid_i,
  input  acc_disp_pkg::trans_id_t head_trans_id_i,
  output logic                    head_nonspec_o,
  acc_req_if.monitor              req
);

  // Received but not yet committed
  logic [acc_disp_pkg::NR_SB_ENTRIES-1:0] pending_d;
  logic [acc_disp_pkg::NR_SB_ENTRIES-1:0] pending_q;
  // Committed but not yet dispatched
  logic [acc_disp_pkg::NR_SB_ENTRIES-1:0] ready_d;
  logic [acc_disp_pkg::NR_SB_ENTRIES-1:0] ready_q;

  logic commit_hit;
  logic dispatch;

  // Commit only counts for an ID the queue actually holds
  assign commit_hit = commit_valid_i && pending_q[commit_trans_id_i];
  assign dispatch = req.valid && req.ready;

  always_comb begin
    pending_d = pending_q;
    ready_d = ready_q;

    // New instruction entered the queue
    if (push_i) begin
      pending_d[push_trans_id_i] = 1'b1;
    end
    // Everything still speculative is dropped
    if (flush_i) begin
      pending_d = '0;
    end

    // Scoreboard head reached, move from pending to ready
    if (commit_hit) begin
      pending_d[commit_trans_id_i] = 1'b0;
      ready_d[commit_trans_id_i] = 1'b1;
    end

    // Dispatch last, so a same-cycle commit and dispatch leaves the bit clear
    if (dispatch) begin
      ready_d[req.trans_id] = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
      ready_q <= '0;
    end else begin
      pending_q <= pending_d;
      ready_q <= ready_d;
    end
  end

  // Head may leave if already committed or committed right now
  assign head_nonspec_o = head_valid_i &&
                          (ready_q[head_trans_id_i] ||
                           (commit_hit && (commit_trans_id_i == head_trans_id_i)));

endmodule

/* src/acc_req_stage.sv */
// One-entry fall-through request register toward the accelerator
`timescale 1ns/100ps

module acc_req_stage (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    acc_req_ready_i,
  acc_req_if.sink                 req,
  output logic                    acc_req_valid_o,
  output acc_disp_pkg::insn_t     acc_insn_o,
  output acc_disp_pkg::xlen_t     acc_rs1_o,
  output acc_disp_pkg::xlen_t     acc_rs2_o,
  output acc_disp_pkg::trans_id_t acc_trans_id_o
);

  logic full_q;
  logic load;

  // Held request payload
  acc_disp_pkg::insn_t     insn_q;
  acc_disp_pkg::xlen_t     rs1_q;
  acc_disp_pkg::xlen_t     rs2_q;
  acc_disp_pkg::trans_id_t trans_id_q;

  // Room only while nothing is held
  assign req.ready = !full_q;

  // Capture when the accelerator does not take the request at once
  assign load = !full_q && req.valid && !acc_req_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      // Held request leaves on accelerator ready
      full_q <= !acc_req_ready_i;
    end else begin
      full_q <= load;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      insn_q <= req.insn;
      rs1_q <= req.rs1;
      rs2_q <= req.rs2;
      trans_id_q <= req.trans_id;
    end
  end

  // Held entry has priority, else pass the offer straight through
  assign acc_req_valid_o = full_q || req.valid;
  assign acc_insn_o = full_q ? insn_q : req.insn;
  assign acc_rs1_o = full_q ? rs1_q : req.rs1;
  assign acc_rs2_o = full_q ? rs2_q : req.rs2;
  assign acc_trans_id_o = full_q ? trans_id_q : req.trans_id;

endmodule

/* src/acc_mem_tracker.sv */
// Accelerator load/store counters, scalar issue stall and store-barrier halt
`timescale 1ns/100ps

module acc_mem_tracker (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  flush_i,
  input  logic                  issue_hs_i,
  input  acc_disp_pkg::fu_e     issue_fu_i,
  input  acc_disp_pkg::acc_op_e issue_acc_op_i,
  input  logic                  queue_full_i,
  input  logic                  acc_load_complete_i,
  input  logic                  acc_store_complete_i,
  input  logic                  acc_store_pending_i,
  input  logic                  commit_st_barrier_i,
  acc_req_if.monitor            req,
  output logic                  issue_stall_o,
  output logic                  ctrl_halt_o
);

  logic accept;
  logic dispatch;
  logic accept_ld;
  logic accept_st;
  logic disp_ld;
  logic disp_st;
  logic ld_pending;
  logic st_pending;
  logic wait_store_d;
  logic wait_store_q;

  // Speculative counts can still be flushed
  acc_disp_pkg::ls_cnt_t spec_ld_q;
  acc_disp_pkg::ls_cnt_t spec_st_q;
  // Dispatched counts live until the accelerator reports completion
  acc_disp_pkg::ls_cnt_t disp_ld_q;
  acc_disp_pkg::ls_cnt_t disp_st_q;

  // Up/down step with clear, up and down together cancel
  function automatic acc_disp_pkg::ls_cnt_t cnt_next(
    input acc_disp_pkg::ls_cnt_t cnt,
    input logic up,
    input logic down,
    input logic clr
  );
    if (clr) begin
      return '0;
    end
    case ({up, down})
      2'b10: return cnt + 1'b1;
      2'b01: return cnt - 1'b1;
      default: return cnt;
    endcase
  endfunction

  assign accept = issue_hs_i && (issue_fu_i == acc_disp_pkg::FU_ACCEL) && !flush_i;
  assign accept_ld = accept && (issue_acc_op_i == acc_disp_pkg::ACC_OP_LOAD);
  assign accept_st = accept && (issue_acc_op_i == acc_disp_pkg::ACC_OP_STORE);

  assign dispatch = req.valid && req.ready;
  assign disp_ld = dispatch && (req.op == acc_disp_pkg::ACC_OP_LOAD);
  assign disp_st = dispatch && (req.op == acc_disp_pkg::ACC_OP_STORE);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      spec_ld_q <= '0;
      spec_st_q <= '0;
      disp_ld_q <= '0;
      disp_st_q <= '0;
    end else begin
      spec_ld_q <= cnt_next(spec_ld_q, accept_ld, disp_ld, flush_i);
      spec_st_q <= cnt_next(spec_st_q, accept_st, disp_st, flush_i);
      disp_ld_q <= cnt_next(disp_ld_q, disp_ld, acc_load_complete_i, 1'b0);
      disp_st_q <= cnt_next(disp_st_q, disp_st, acc_store_complete_i, 1'b0);
    end
  end

  assign ld_pending = (spec_ld_q != '0) || (disp_ld_q != '0);
  assign st_pending = (spec_st_q != '0) || (disp_st_q != '0);

  // Stall choice follows the unit at issue
  always_comb begin
    case (issue_fu_i)
      acc_disp_pkg::FU_ACCEL: issue_stall_o = queue_full_i;
      // Scalar load may not pass an accelerator store
      acc_disp_pkg::FU_LOAD: issue_stall_o = st_pending;
      // Scalar store may not pass any accelerator memory access
      acc_disp_pkg::FU_STORE: issue_stall_o = st_pending || ld_pending;
      default: issue_stall_o = 1'b0;
    endcase
  end

  // Set by a committed barrier, held until no store is pending
  assign wait_store_d = (wait_store_q || commit_st_barrier_i) && acc_store_pending_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wait_store_q <= 1'b0;
    end else begin
      wait_store_q <= wait_store_d;
    end
  end

  assign ctrl_halt_o = wait_store_q;

endmodule

/* src/acc_dispatcher.sv */
// Accelerator dispatcher top level with queue, trackers, request register and response path
`timescale 1ns/100ps

module acc_dispatcher (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // Issue stage
  input  logic                    issue_hs_i,
  input  acc_disp_pkg::fu_e       issue_fu_i,
  input  acc_disp_pkg::acc_op_e   issue_acc_op_i,
  input  acc_disp_pkg::insn_t     issue_insn_i,
  input  acc_disp_pkg::xlen_t     issue_rs1_i,
  input  acc_disp_pkg::xlen_t     issue_rs2_i,
  input  acc_disp_pkg::trans_id_t issue_trans_id_i,
  output logic                    issue_stall_o,
  input  logic                    flush_i,
  // Commit stage
  input  logic                    commit_valid_i,
  input  acc_disp_pkg::trans_id_t commit_trans_id_i,
  input  logic                    commit_st_barrier_i,
  output logic                    ctrl_halt_o,
  // Accelerator request
  output logic                    acc_req_valid_o,
  input  logic                    acc_req_ready_i,
  output acc_disp_pkg::insn_t     acc_insn_o,
  output acc_disp_pkg::xlen_t     acc_rs1_o,
  output acc_disp_pkg::xlen_t     acc_rs2_o,
  output acc_disp_pkg::trans_id_t acc_trans_id_o,
  // Accelerator response
  input  logic                    acc_resp_valid_i,
  input  acc_disp_pkg::trans_id_t acc_resp_trans_id_i,
  input  acc_disp_pkg::xlen_t     acc_resp_result_i,
  input  logic                    acc_resp_error_i,
  input  logic                    acc_load_complete_i,
  input  logic                    acc_store_complete_i,
  input  logic                    acc_store_pending_i,
  // Writeback
  output logic                    result_valid_o,
  output acc_disp_pkg::trans_id_t result_trans_id_o,
  output acc_disp_pkg::xlen_t     result_o,
  output logic                    exception_valid_o
);

  logic                    push;
  logic                    head_valid;
  logic                    head_nonspec;
  logic                    queue_full;
  acc_disp_pkg::trans_id_t head_trans_id;

  acc_req_if req_if ();

  // Accelerator instruction accepted at issue, a flush drops it
  assign push = issue_hs_i && (issue_fu_i == acc_disp_pkg::FU_ACCEL) && !flush_i;

  acc_insn_queue insn_queue_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .push_i          (push),
    .flush_i         (flush_i),
    .insn_i          (issue_insn_i),
    .rs1_i           (issue_rs1_i),
    .rs2_i           (issue_rs2_i),
    .trans_id_i      (issue_trans_id_i),
    .op_i            (issue_acc_op_i),
    .head_nonspec_i  (head_nonspec),
    .head_valid_o    (head_valid),
    .head_trans_id_o (head_trans_id),
    .queue_full_o    (queue_full),
    .req             (req_if.source)
  );

  acc_spec_tracker spec_tracker_i (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .flush_i           (flush_i),
    .push_i            (push),
    .push_trans_id_i   (issue_trans_id_i),
    .commit_valid_i    (commit_valid_i),
    .commit_trans_id_i (commit_trans_id_i),
    .head_valid_i      (head_valid),
    .head_trans_id_i   (head_trans_id),
    .head_nonspec_o    (head_nonspec),
    .req               (req_if.monitor)
  );

  acc_req_stage req_stage_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .acc_req_ready_i (acc_req_ready_i),
    .req             (req_if.sink),
    .acc_req_valid_o (acc_req_valid_o),
    .acc_insn_o      (acc_insn_o),
    .acc_rs1_o       (acc_rs1_o),
    .acc_rs2_o       (acc_rs2_o),
    .acc_trans_id_o  (acc_trans_id_o)
  );

  acc_mem_tracker mem_tracker_i (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .flush_i              (flush_i),
    .issue_hs_i           (issue_hs_i),
    .issue_fu_i           (issue_fu_i),
    .issue_acc_op_i       (issue_acc_op_i),
    .queue_full_i         (queue_full),
    .acc_load_complete_i  (acc_load_complete_i),
    .acc_store_complete_i (acc_store_complete_i),
    .acc_store_pending_i  (acc_store_pending_i),
    .commit_st_barrier_i  (commit_st_barrier_i),
    .req                  (req_if.monitor),
    .issue_stall_o        (issue_stall_o),
    .ctrl_halt_o          (ctrl_halt_o)
  );

  // Responses are always accepted and forwarded unregistered
  assign result_valid_o = acc_resp_valid_i;
  assign result_trans_id_o = acc_resp_trans_id_i;
  assign result_o = acc_resp_result_i;
  // Accelerator error raises an illegal-instruction exception
  assign exception_valid_o = acc_resp_valid_i && acc_resp_error_i;

endmodule

/* test/acc_dispatcher_tb.sv */
// Directed testbench for the accelerator dispatcher with issue model, checks and timeout
`timescale 1ns/100ps

module acc_dispatcher_tb;

  localparam int RESET_CYCLES = 10;
  // Six tests of well under 300 cycles each, plus reset and margin
  localparam int TIMEOUT_CYCLES = 2000;

  // One issued instruction as the accelerator should see it
  typedef struct packed {
    acc_disp_pkg::insn_t     insn;
    acc_disp_pkg::xlen_t     rs1;
    acc_disp_pkg::xlen_t     rs2;
    acc_disp_pkg::trans_id_t id;
  } req_rec_t;

  logic clk_i;
  logic reset_i;
  logic issue_hs_i;
  acc_disp_pkg::fu_e issue_fu_i;
  acc_disp_pkg::acc_op_e issue_acc_op_i;
  acc_disp_pkg::insn_t issue_insn_i;
  acc_disp_pkg::xlen_t issue_rs1_i;
  acc_disp_pkg::xlen_t issue_rs2_i;
  acc_disp_pkg::trans_id_t issue_trans_id_i;
  logic issue_stall_o;
  logic flush_i;
  logic commit_valid_i;
  acc_disp_pkg::trans_id_t commit_trans_id_i;
  logic commit_st_barrier_i;
  logic ctrl_halt_o;
  logic acc_req_valid_o;
  logic acc_req_ready_i;
  acc_disp_pkg::insn_t acc_insn_o;
  acc_disp_pkg::xlen_t acc_rs1_o;
  acc_disp_pkg::xlen_t acc_rs2_o;
  acc_disp_pkg::trans_id_t acc_trans_id_o;
  logic acc_resp_valid_i;
  acc_disp_pkg::trans_id_t acc_resp_trans_id_i;
  acc_disp_pkg::xlen_t acc_resp_result_i;
  logic acc_resp_error_i;
  logic acc_load_complete_i;
  logic acc_store_complete_i;
  logic acc_store_pending_i;
  logic result_valid_o;
  acc_disp_pkg::trans_id_t result_trans_id_o;
  acc_disp_pkg::xlen_t result_o;
  logic exception_valid_o;

  int errors;
  int checks;
  int tests_run;
  int cycles;
  // Issued and not yet taken by the accelerator, in issue order
  req_rec_t expected_q[$];

  acc_dispatcher dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Cycle limit, stops a hung run
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Run stopped after %0d cycles, a test never finished", cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_cond(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error at %0t ns: %s", $time, what);
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - start_errors);
    end
  endtask

  // One issue handshake with random payload, recorded in the model
  task automatic issue_insn(input acc_disp_pkg::trans_id_t id, input acc_disp_pkg::acc_op_e op);
    req_rec_t rec;
    rec.insn = $urandom;
    rec.rs1 = {$urandom, $urandom};
    rec.rs2 = {$urandom, $urandom};
    rec.id = id;
    issue_hs_i = 1'b1;
    issue_fu_i = acc_disp_pkg::FU_ACCEL;
    issue_acc_op_i = op;
    issue_insn_i = rec.insn;
    issue_rs1_i = rec.rs1;
    issue_rs2_i = rec.rs2;
    issue_trans_id_i = id;
    #1;
    // Issue never handshakes into a stall
    check_val("issue_stall_o", 64'(issue_stall_o), 64'd0);
    expected_q.push_back(rec);
    @(negedge clk_i);
    issue_hs_i = 1'b0;
    issue_fu_i = acc_disp_pkg::FU_NONE;
    issue_acc_op_i = acc_disp_pkg::ACC_OP_OTHER;
  endtask

  task automatic commit_id(input acc_disp_pkg::trans_id_t id);
    commit_valid_i = 1'b1;
    commit_trans_id_i = id;
    @(negedge clk_i);
    commit_valid_i = 1'b0;
  endtask

  // Wait for an accelerator handshake and compare it with the oldest issued entry
  task automatic take_request(input int max_cycles);
    int waited;
    logic seen;
    req_rec_t rec;
    waited = 0;
    seen = 1'b0;
    #1;
    while (!seen && waited < max_cycles) begin
      if (acc_req_valid_o && acc_req_ready_i) begin
        seen = 1'b1;
      end else begin
        @(negedge clk_i);
        #1;
        waited++;
      end
    end
    check_cond(seen, "no accelerator request appeared in time");
    if (seen) begin
      check_cond(expected_q.size() != 0, "accelerator request with nothing issued");
      if (expected_q.size() != 0) begin
        rec = expected_q.pop_front();
        check_val("acc_insn_o", 64'(acc_insn_o), 64'(rec.insn));
        check_val("acc_rs1_o", acc_rs1_o, rec.rs1);
        check_val("acc_rs2_o", acc_rs2_o, rec.rs2);
        check_val("acc_trans_id_o", 64'(acc_trans_id_o), 64'(rec.id));
      end
    end
    @(negedge clk_i);
  endtask

  // Commit held through the cycle in which the request leaves
  task automatic commit_and_take(input acc_disp_pkg::trans_id_t id);
    commit_valid_i = 1'b1;
    commit_trans_id_i = id;
    take_request(4);
    commit_valid_i = 1'b0;
  endtask

  task automatic expect_no_request(input int n);
    repeat (n) begin
      #1;
      check_val("acc_req_valid_o", 64'(acc_req_valid_o), 64'd0);
      @(negedge clk_i);
    end
  endtask

  // Present a unit at issue for one cycle and check the stall
  task automatic check_stall(input acc_disp_pkg::fu_e fu, input logic exp);
    issue_fu_i = fu;
    #1;
    check_val("issue_stall_o", 64'(issue_stall_o), 64'(exp));
    @(negedge clk_i);
    issue_fu_i = acc_disp_pkg::FU_NONE;
  endtask

  task automatic pulse_completion(input logic is_store);
    acc_store_complete_i = is_store;
    acc_load_complete_i = !is_store;
    @(negedge clk_i);
    acc_store_complete_i = 1'b0;
    acc_load_complete_i = 1'b0;
  endtask

  task automatic check_reset_state();
    check_stall(acc_disp_pkg::FU_ACCEL, 1'b0);
    check_stall(acc_disp_pkg::FU_LOAD, 1'b0);
    check_stall(acc_disp_pkg::FU_STORE, 1'b0);
    #1;
    check_val("acc_req_valid_o", 64'(acc_req_valid_o), 64'd0);
    check_val("ctrl_halt_o", 64'(ctrl_halt_o), 64'd0);
    @(negedge clk_i);
  endtask

  task automatic test_nonspec_dispatch();
    int start_errors;
    start_errors = errors;
    acc_req_ready_i = 1'b1;
    issue_insn(3'd1, acc_disp_pkg::ACC_OP_OTHER);
    // Still speculative, must not leave
    expect_no_request(10);
    commit_and_take(3'd1);
    report_test("Test 1 non-speculative dispatch", start_errors);
  endtask

  task automatic test_order_backpressure();
    int start_errors;
    req_rec_t front;
    start_errors = errors;
    acc_req_ready_i = 1'b0;
    // One request held in the register, three in the queue
    for (int i = 0; i < 4; i++) begin
      issue_insn(acc_disp_pkg::trans_id_t'(i + 2), acc_disp_pkg::ACC_OP_OTHER);
      commit_id(acc_disp_pkg::trans_id_t'(i + 2));
    end
    front = expected_q[0];
    issue_fu_i = acc_disp_pkg::FU_ACCEL;
    repeat (5) begin
      #1;
      check_val("acc_req_valid_o", 64'(acc_req_valid_o), 64'd1);
      check_val("acc_insn_o", 64'(acc_insn_o), 64'(front.insn));
      check_val("acc_rs1_o", acc_rs1_o, front.rs1);
      check_val("acc_rs2_o", acc_rs2_o, front.rs2);
      check_val("acc_trans_id_o", 64'(acc_trans_id_o), 64'(front.id));
      check_val("issue_stall_o", 64'(issue_stall_o), 64'd1);
      @(negedge clk_i);
    end
    issue_fu_i = acc_disp_pkg::FU_NONE;
    acc_req_ready_i = 1'b1;
    repeat (4) take_request(4);
    check_stall(acc_disp_pkg::FU_ACCEL, 1'b0);
    report_test("Test 2 order and back-pressure", start_errors);
  endtask

  task automatic test_flush();
    int start_errors;
    start_errors = errors;
    acc_req_ready_i = 1'b1;
    issue_insn(3'd6, acc_disp_pkg::ACC_OP_LOAD);
    // Speculative load blocks scalar stores until flushed
    check_stall(acc_disp_pkg::FU_STORE, 1'b1);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    // Flushed instruction is gone from the model too
    void'(expected_q.pop_back());
    check_stall(acc_disp_pkg::FU_STORE, 1'b0);
    commit_id(3'd6);
    expect_no_request(10);
    report_test("Test 3 flush", start_errors);
  endtask

  task automatic test_load_store_order();
    int start_errors;
    start_errors = errors;
    acc_req_ready_i = 1'b1;
    issue_insn(3'd7, acc_disp_pkg::ACC_OP_STORE);
    // Speculative store already blocks scalar loads
    check_stall(acc_disp_pkg::FU_LOAD, 1'b1);
    commit_and_take(3'd7);
    repeat (3) check_stall(acc_disp_pkg::FU_LOAD, 1'b1);
    check_stall(acc_disp_pkg::FU_STORE, 1'b1);
    pulse_completion(1'b1);
    check_stall(acc_disp_pkg::FU_LOAD, 1'b0);
    check_stall(acc_disp_pkg::FU_STORE, 1'b0);
    // Outstanding load blocks scalar stores only
    issue_insn(3'd0, acc_disp_pkg::ACC_OP_LOAD);
    commit_and_take(3'd0);
    check_stall(acc_disp_pkg::FU_LOAD, 1'b0);
    repeat (3) check_stall(acc_disp_pkg::FU_STORE, 1'b1);
    pulse_completion(1'b0);
    check_stall(acc_disp_pkg::FU_STORE, 1'b0);
    report_test("Test 4 load/store ordering", start_errors);
  endtask

  task automatic test_store_barrier();
    int start_errors;
    start_errors = errors;
    // Barrier with no store pending does not halt
    commit_st_barrier_i = 1'b1;
    @(negedge clk_i);
    commit_st_barrier_i = 1'b0;
    #1;
    check_val("ctrl_halt_o", 64'(ctrl_halt_o), 64'd0);
    @(negedge clk_i);
    acc_store_pending_i = 1'b1;
    commit_st_barrier_i = 1'b1;
    #1;
    check_val("ctrl_halt_o", 64'(ctrl_halt_o), 64'd0);
    @(negedge clk_i);
    commit_st_barrier_i = 1'b0;
    repeat (4) begin
      #1;
      check_val("ctrl_halt_o", 64'(ctrl_halt_o), 64'd1);
      @(negedge clk_i);
    end
    acc_store_pending_i = 1'b0;
    #1;
    check_val("ctrl_halt_o", 64'(ctrl_halt_o), 64'd1);
    @(negedge clk_i);
    #1;
    check_val("ctrl_halt_o", 64'(ctrl_halt_o), 64'd0);
    @(negedge clk_i);
    report_test("Test 5 store barrier", start_errors);
  endtask

  task automatic test_response_path();
    int start_errors;
    logic valid;
    logic error;
    acc_disp_pkg::trans_id_t id;
    acc_disp_pkg::xlen_t result;
    start_errors = errors;
    repeat (16) begin
      valid = 1'($urandom);
      error = 1'($urandom);
      id = acc_disp_pkg::trans_id_t'($urandom);
      result = {$urandom, $urandom};
      acc_resp_valid_i = valid;
      acc_resp_error_i = error;
      acc_resp_trans_id_i = id;
      acc_resp_result_i = result;
      #1;
      check_val("result_valid_o", 64'(result_valid_o), 64'(valid));
      check_val("result_trans_id_o", 64'(result_trans_id_o), 64'(id));
      check_val("result_o", result_o, result);
      // Error only raises an exception with a valid response
      check_val("exception_valid_o", 64'(exception_valid_o), 64'(valid && error));
      @(negedge clk_i);
    end
    acc_resp_valid_i = 1'b0;
    acc_resp_error_i = 1'b0;
    report_test("Test 6 response pass-through", start_errors);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    tests_run = 0;
    void'($urandom(32'h1987));
    reset_i = 1'b1;
    issue_hs_i = 1'b0;
    issue_fu_i = acc_disp_pkg::FU_NONE;
    issue_acc_op_i = acc_disp_pkg::ACC_OP_OTHER;
    issue_insn_i = '0;
    issue_rs1_i = '0;
    issue_rs2_i = '0;
    issue_trans_id_i = '0;
    flush_i = 1'b0;
    commit_valid_i = 1'b0;
    commit_trans_id_i = '0;
    commit_st_barrier_i = 1'b0;
    acc_req_ready_i = 1'b0;
    acc_resp_valid_i = 1'b0;
    acc_resp_trans_id_i = '0;
    acc_resp_result_i = '0;
    acc_resp_error_i = 1'b0;
    acc_load_complete_i = 1'b0;
    acc_store_complete_i = 1'b0;
    acc_store_pending_i = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    reset_i = 1'b0;
    check_reset_state();
    test_nonspec_dispatch();
    test_order_backpressure();
    test_flush();
    test_load_store_order();
    test_store_barrier();
    test_response_path();
    $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
src/acc_disp_pkg.sv
src/acc_req_if.sv
src/acc_insn_queue.sv
src/acc_spec_tracker.sv
src/acc_req_stage.sv
src/acc_mem_tracker.sv
src/acc_dispatcher.sv
test/acc_dispatcher_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = acc_dispatcher_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = TESTBENCH PASSED

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

.PHONY: sim clean
